//--- htif_bridge_input.txt
// columns: op arg1 arg2 arg3 (hex). 1 write addr data, 2 read addr data err, 3 send word,
// 4 expect word on host_in, 5 ready mode, 6 target_reset cycles, 7 host_in.valid, 8 stalled write addr data cycles, 9 idle cycles, 0 end
7 0 0 0
2 0 0 0
2 4 0 1
// downlink with random ready
5 1 0 0
1 0 11223344 0
1 0 a5a55a5a 0
1 0 deadbeef 0
4 11223344 0 0
4 a5a55a5a 0 0
4 deadbeef 0 0
// uplink pairing and count
3 cafe0001 0 0
3 87654321 0 0
3 0badf00d 0 0
9 2 0 0
2 0 3 0
2 4 cafe0001 0
2 0 2 0
2 4 87654321 0
2 0 1 0
2 8 0 0
// target reset keeps queued data
5 0 0 0
1 0 13572468 0
1 7c 0 0
6 1 0 0
7 1 0 0
2 0 1 0
2 4 0badf00d 0
5 1 0 0
4 13572468 0 0
// back-pressure on the fifth write
5 0 0 0
1 0 00010002 0
1 0 00030004 0
1 0 00050006 0
1 0 00070008 0
8 0 0009000a 3
4 00010002 0 0
4 00030004 0 0
4 00050006 0 0
4 00070008 0 0
4 0009000a 0 0
2 0 0 0
2 4 0 1
0 0 0 0

//--- htif_bridge.f
htif_regs_pkg.sv
htif_link_pkg.sv
htif_fifo.sv
htif_apb_regs.sv
htif_downlink.sv
htif_uplink.sv
htif_bridge.sv
tb_clock_gen.sv
htif_bridge_tb.sv

//--- Makefile
TOP = htif_bridge_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f htif_bridge.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- htif_bridge_tb.sv
module htif_bridge_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int CYCLES_PER_OP = 40;

  logic clk;
  logic reset;
  htif_regs_pkg::apb_req_t apb_req;
  htif_regs_pkg::apb_rsp_t apb_rsp;
  htif_link_pkg::link_flit_t host_in;
  logic host_in_ready;
  htif_link_pkg::link_flit_t host_out;
  logic host_out_ready;
  logic target_reset;

  // each operation takes four hex words for op and three arguments
  logic [31:0] stim [0:255];
  logic [15:0] rx_q [$];
  integer seed = 32'hfadd;
  int ready_mode;
  int reset_cycles;
  int up_words;
  int cycles;
  int limit;
  int checks;
  int mismatches;
  int other_errors;

  tb_clock_gen #(
    .PERIOD(100),
    .RESET_CYCLES(2)
  ) clock_gen (
    .clk(clk),
    .reset(reset)
  );

  htif_bridge #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .clk(clk),
    .reset(reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .host_in(host_in),
    .host_in_ready(host_in_ready),
    .host_out(host_out),
    .host_out_ready(host_out_ready),
    .target_reset(target_reset)
  );

  // handshake and pulse are sampled mid-cycle where they are settled
  always @(negedge clk)
  begin
    if (!reset && host_in.valid && host_in_ready)
      rx_q.push_back(host_in.bits);
    if (!reset && target_reset)
      reset_cycles++;
  end

  // mode 0 holds target ready low and mode 1 makes it random
  initial
  begin : ready_drive
    logic [31:0] rnd;
    int mode_now;
    host_in_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      mode_now = ready_mode;
      rnd = $random(seed);
      #10;
      host_in_ready = (mode_now == 1) ? rnd[0] : 1'b0;
    end
  end

  task automatic report_counts();
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      report_counts();
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      mismatches++;
      $display("MISMATCH %s: actual %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic apb_setup(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = wr;
    apb_req.paddr = addr;
    apb_req.pwdata = data;
    next_cycle();
    apb_req.penable = 1'b1;
  endtask

  // called at the negedge of the completing cycle
  task automatic apb_release();
    next_cycle();
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    apb_setup(1'b1, addr, data);
    @(negedge clk);
    while (!apb_rsp.pready)
      @(negedge clk);
    apb_release();
  endtask

  task automatic apb_read(input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] err);
    apb_setup(1'b0, addr, 32'd0);
    @(negedge clk);
    while (!apb_rsp.pready)
      @(negedge clk);
    check_value("prdata", apb_rsp.prdata, data);
    check_value("pslverr", 32'(apb_rsp.pslverr), err);
    // a successful data read takes one word out of the uplink
    if (addr[6:2] == htif_regs_pkg::REG_RD_DATA && err == 32'd0)
      up_words--;
    apb_release();
  endtask

  // write into a full downlink and then let the target drain it
  task automatic apb_write_stalled(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [31:0] stall);
    apb_setup(1'b1, addr, data);
    repeat (stall)
    begin
      @(negedge clk);
      check_value("pready", 32'(apb_rsp.pready), 32'd0);
    end
    ready_mode = 1;
    @(negedge clk);
    while (!apb_rsp.pready)
      @(negedge clk);
    apb_release();
  endtask

  task automatic send_half(input logic [15:0] half);
    host_out.valid = 1'b1;
    host_out.bits = half;
    @(negedge clk);
    // below capacity the uplink takes the half at once
    if (up_words < FIFO_DEPTH)
      check_value("host_out_ready", 32'(host_out_ready), 32'd1);
    while (!host_out_ready)
      @(negedge clk);
    next_cycle();
  endtask

  task automatic expect_word(input logic [31:0] word);
    logic [15:0] lo;
    logic [15:0] hi;
    while (rx_q.size() < 2)
      next_cycle();
    lo = rx_q.pop_front();
    hi = rx_q.pop_front();
    check_value("host_in.bits", 32'(lo), 32'(word[15:0]));
    check_value("host_in.bits", 32'(hi), 32'(word[31:16]));
  endtask

  initial
  begin : run
    logic [7:0] wp;
    logic [31:0] op;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    apb_req = '0;
    host_out = '0;
    $readmemh("htif_bridge_input.txt", stim);
    wp = '0;
    while (stim[wp] != 32'd0)
      wp = wp + 8'd4;
    limit = CYCLES_PER_OP * (int'(wp) / 4 + 1);
    @(negedge reset);
    wp = '0;
    while (stim[wp] != 32'd0)
    begin
      op = stim[wp];
      a1 = stim[wp + 8'd1];
      a2 = stim[wp + 8'd2];
      a3 = stim[wp + 8'd3];
      case (op)
        32'd1: apb_write(a1, a2);
        32'd2: apb_read(a1, a2, a3);
        32'd3:
        begin
          send_half(a1[15:0]);
          send_half(a1[31:16]);
          host_out.valid = 1'b0;
          up_words++;
        end
        32'd4: expect_word(a1);
        32'd5: ready_mode = int'(a1);
        32'd6:
        begin
          repeat (3) next_cycle();
          check_value("target_reset cycles", 32'(reset_cycles), a1);
          reset_cycles = 0;
        end
        32'd7:
        begin
          @(negedge clk);
          check_value("host_in.valid", 32'(host_in.valid), a1);
          next_cycle();
        end
        32'd8: apb_write_stalled(a1, a2, a3);
        32'd9: repeat (a1) next_cycle();
        default:
        begin
          other_errors++;
          $display("the data file holds an unknown operation code %0h", op);
        end
      endcase
      wp = wp + 8'd4;
    end
    report_counts();
    if (mismatches == 0 && other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

  // reset drops a little after its last rising edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 reset = 1'b0;
  end

endmodule

//--- htif_bridge.sv
module htif_bridge #(
  parameter int FIFO_DEPTH = 32
) (
  input logic clk,
  input logic reset,
  input htif_regs_pkg::apb_req_t apb_req,
  output htif_regs_pkg::apb_rsp_t apb_rsp,
  output htif_link_pkg::link_flit_t host_in,
  input logic host_in_ready,
  input htif_link_pkg::link_flit_t host_out,
  output logic host_out_ready,
  output logic target_reset
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic push;
  logic push_ok;
  logic pop;
  logic up_empty;
  logic [CW-1:0] up_count;
  htif_link_pkg::htif_word_u push_word;
  htif_link_pkg::htif_word_u pop_word;

  htif_apb_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_apb_regs (
    .clk(clk),
    .reset(reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .push(push),
    .push_word(push_word),
    .push_ok(push_ok),
    .pop(pop),
    .pop_word(pop_word),
    .up_empty(up_empty),
    .up_count(up_count),
    .target_reset(target_reset)
  );

  htif_downlink #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_downlink (
    .clk(clk),
    .reset(reset),
    .push(push),
    .push_word(push_word),
    .push_ok(push_ok),
    .host_in(host_in),
    .host_in_ready(host_in_ready)
  );

  htif_uplink #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_uplink (
    .clk(clk),
    .reset(reset),
    .host_out(host_out),
    .host_out_ready(host_out_ready),
    .pop(pop),
    .pop_word(pop_word),
    .empty(up_empty),
    .count(up_count)
  );

endmodule

//--- htif_uplink.sv
module htif_uplink #(
  parameter int FIFO_DEPTH = 32
) (
  input logic clk,
  input logic reset,
  input htif_link_pkg::link_flit_t host_out,
  output logic host_out_ready,
  input logic pop,
  output htif_link_pkg::htif_word_u pop_word,
  output logic empty,
  output logic [$clog2(FIFO_DEPTH + 1) - 1:0] count
);

  htif_link_pkg::half_t lo_r;
  htif_link_pkg::htif_word_u pend_word;
  logic pend_valid;
  logic phase_hi;
  logic accept;
  logic full;

  assign host_out_ready = !full;
  assign accept = host_out.valid && host_out_ready;

  // low half parked in lo_r, pair goes to the fifo a cycle after the high half
  always_ff @(posedge clk)
  begin
    if (accept && !phase_hi)
      lo_r <= host_out.bits;
    if (accept && phase_hi)
    begin
      pend_word.halves.hi <= host_out.bits;
      pend_word.halves.lo <= lo_r;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase_hi <= 1'b0;
      pend_valid <= 1'b0;
    end
    else
    begin
      pend_valid <= accept && phase_hi;
      if (accept)
        phase_hi <= !phase_hi;
    end
  end

  htif_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk),
    .reset(reset),
    .wr_en(pend_valid),
    .rd_en(pop),
    .wr_data(pend_word),
    .rd_data(pop_word),
    .empty(empty),
    .full(full),
    .count(count)
  );

endmodule

//--- htif_downlink.sv
module htif_downlink #(
  parameter int FIFO_DEPTH = 32
) (
  input logic clk,
  input logic reset,
  input logic push,
  input htif_link_pkg::htif_word_u push_word,
  output logic push_ok,
  output htif_link_pkg::link_flit_t host_in,
  input logic host_in_ready
);

  htif_link_pkg::htif_word_u head;
  logic empty;
  logic full;
  logic sel_hi;
  logic half_done;

  htif_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk),
    .reset(reset),
    .wr_en(push),
    .rd_en(half_done && sel_hi),
    .wr_data(push_word),
    .rd_data(head),
    .empty(empty),
    .full(full),
    .count()
  );

  assign push_ok = !full;

  // low half first, word leaves the fifo once the high half is taken
  assign host_in.valid = !empty;
  assign host_in.bits = sel_hi ? head.halves.hi : head.halves.lo;
  assign half_done = host_in.valid && host_in_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
      sel_hi <= 1'b0;
    else if (half_done)
      sel_hi <= !sel_hi;
  end

  // the target may stall, the offered half must not change under it
  assert property (@(posedge clk) disable iff (reset)
    host_in.valid && !host_in_ready |=> host_in.valid && $stable(host_in.bits))
    else $error("htif_downlink: host_in dropped or changed before accept");

endmodule

//--- htif_apb_regs.sv
module htif_apb_regs #(
  parameter int FIFO_DEPTH = 32
) (
  input logic clk,
  input logic reset,
  input htif_regs_pkg::apb_req_t apb_req,
  output htif_regs_pkg::apb_rsp_t apb_rsp,
  output logic push,
  output htif_link_pkg::htif_word_u push_word,
  input logic push_ok,
  output logic pop,
  input htif_link_pkg::htif_word_u pop_word,
  input logic up_empty,
  input logic [$clog2(FIFO_DEPTH + 1) - 1:0] up_count,
  output logic target_reset
);

  htif_regs_pkg::reg_addr_t idx;
  logic access;
  logic wr_data_sel;
  logic rd_data_sel;
  logic reset_sel;
  logic [31:0] read_data;

  assign idx = apb_req.paddr[6:2];
  assign access = apb_req.psel && apb_req.penable;

  assign wr_data_sel = apb_req.pwrite && (idx == htif_regs_pkg::REG_WR_DATA);
  assign rd_data_sel = !apb_req.pwrite && (idx == htif_regs_pkg::REG_RD_DATA);
  assign reset_sel = apb_req.pwrite && (idx == htif_regs_pkg::REG_TARGET_RESET);

  // data writes wait for room in the downlink, everything else is zero wait
  assign apb_rsp.pready = !wr_data_sel || push_ok;

  // strobes fire only in the completing access cycle
  assign push = access && wr_data_sel && push_ok;
  assign push_word.raw = apb_req.pwdata;
  assign pop = access && rd_data_sel && !up_empty;

  // reading an empty uplink is an error and leaves the fifo alone
  assign apb_rsp.pslverr = access && rd_data_sel && up_empty;

  always_comb
  begin
    read_data = '0;
    if (!apb_req.pwrite)
    begin
      case (idx)
        htif_regs_pkg::REG_COUNT: read_data = 32'(up_count);
        htif_regs_pkg::REG_RD_DATA:
        begin
          if (!up_empty)
            read_data = pop_word.raw;
        end
        default: read_data = '0;
      endcase
    end
  end

  assign apb_rsp.prdata = read_data;

  // one cycle pulse after the write to index 31 completes
  always_ff @(posedge clk)
  begin
    if (reset)
      target_reset <= 1'b0;
    else
      target_reset <= access && reset_sel;
  end

  // host side protocol check
  assert property (@(posedge clk) disable iff (reset) apb_req.penable |-> apb_req.psel)
    else $error("htif_apb_regs: penable without psel");

endmodule

//--- htif_fifo.sv
module htif_fifo #(
  parameter int FIFO_DEPTH = 32
) (
  input logic clk,
  input logic reset,
  input logic wr_en,
  input logic rd_en,
  input htif_link_pkg::htif_word_u wr_data,
  output htif_link_pkg::htif_word_u rd_data,
  output logic empty,
  output logic full,
  output logic [$clog2(FIFO_DEPTH + 1) - 1:0] count
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  htif_link_pkg::htif_word_u mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr_next;
  logic [AW-1:0] rd_ptr_next;
  logic [CW-1:0] cnt;
  logic wr_ok;
  logic rd_ok;

  // a full fifo still takes a write when a read frees a slot
  assign wr_ok = wr_en && (!full || rd_en);
  assign rd_ok = rd_en && !empty;

  // pointers wrap on their own since depth is a power of two
  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  // first-word fall-through
  assign rd_data = mem[rd_ptr];
  assign count = cnt;

  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt <= '0;
      empty <= 1'b1;
      full <= 1'b0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr_next;
      if (rd_ok)
        rd_ptr <= rd_ptr_next;

      if (wr_ok && !rd_ok)
      begin
        cnt <= cnt + 1'b1;
        empty <= 1'b0;
        full <= (wr_ptr_next == rd_ptr);
      end
      else if (rd_ok && !wr_ok)
      begin
        cnt <= cnt - 1'b1;
        full <= 1'b0;
        empty <= (rd_ptr_next == wr_ptr);
      end
    end
  end

  // producers and consumers must honour full and empty themselves
  assert property (@(posedge clk) disable iff (reset) wr_en |-> (!full || rd_en))
    else $error("htif_fifo: write while full");
  assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("htif_fifo: read while empty");

endmodule

//--- htif_link_pkg.sv
package htif_link_pkg;

  // one transfer on the target link
  typedef logic [15:0] half_t;

  // a host word split into link halves, low half goes first on the wire
  typedef struct packed {
    half_t hi;
    half_t lo;
  } half_pair_t;

  // host side uses raw, link side uses halves
  typedef union packed {
    logic [31:0] raw;
    half_pair_t halves;
  } htif_word_u;

  // valid/ready link flit, ready travels separately
  typedef struct packed {
    logic valid;
    half_t bits;
  } link_flit_t;

endpackage

//--- htif_regs_pkg.sv
package htif_regs_pkg;

  // register index, taken from paddr[6:2]
  typedef logic [4:0] reg_addr_t;

  // read side
  localparam reg_addr_t REG_COUNT = 5'd0;
  localparam reg_addr_t REG_RD_DATA = 5'd1;

  // write side
  localparam reg_addr_t REG_WR_DATA = 5'd0;
  localparam reg_addr_t REG_TARGET_RESET = 5'd31;

  // host request into the slave
  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // slave response back to the host
  typedef struct packed {
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

endpackage
